// ==== logic/hv_pkg.sv ====
package hv_pkg;

    //========================================
    // control fsm
    //========================================
    typedef enum logic [1:0] {
        ST_WAIT     = 2'd0,
        ST_CFG      = 2'd1,
        ST_NORMAL   = 2'd2,
        ST_FAILSAFE = 2'd3
    } ctrl_st_e;

    typedef enum logic [2:0] {
        CMD_NOP     = 3'd0,
        CMD_CFG     = 3'd1,
        CMD_NORMAL  = 3'd2,
        CMD_RESET   = 3'd3,
        CMD_CLR_FLT = 3'd4
    } mode_cmd_e;

    //========================================
    // analog fault flags
    //========================================
    localparam int FLT_NUM = 6;

    localparam int FLT_UV    = 0; // vcc undervoltage
    localparam int FLT_OV    = 1; // vcc overvoltage
    localparam int FLT_OT    = 2;
    localparam int FLT_OC    = 3;
    localparam int FLT_DESAT = 4;
    localparam int FLT_SCP   = 5; // short circuit

    typedef logic [FLT_NUM-1:0] flt_vec_t;

    localparam int FLT_DEB_CYC = 4;
    localparam int FLT_DEB_W   = $clog2(FLT_DEB_CYC + 1);

    //========================================
    // watchdog
    //========================================
    localparam int WDG_SEL_W = 2;
    localparam int WDG_CNT_W = 10;

    // timeout limits in clock cycles, index 0 is the shortest
    localparam logic [2**WDG_SEL_W-1:0][WDG_CNT_W-1:0] WDG_TMO_CYC = {
        10'd512, 10'd256, 10'd128, 10'd64
    };

endpackage

// ==== logic/hv_ctrl_fsm.sv ====
`timescale 1ns/1ps

module hv_ctrl_fsm (
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              i_cmd_vld,
    input  hv_pkg::mode_cmd_e i_cmd,
    input  logic              i_flt_any,
    input  logic              i_wdg_tmo,
    input  logic              i_fs_req,
    output hv_pkg::ctrl_st_e  o_ctrl_st,
    output logic              o_pwm_en,
    output logic              o_fsc_en,
    output logic              o_wdg_en,
    output logic              o_flt_clr,
    output logic              o_intb_n
);

    hv_pkg::ctrl_st_e st_nxt;
    logic             fs_trig;
    logic             st_active; // cfg or normal

    assign fs_trig   = i_flt_any | i_wdg_tmo | i_fs_req;
    assign st_active = (o_ctrl_st == hv_pkg::ST_CFG) || (o_ctrl_st == hv_pkg::ST_NORMAL);

    //========================================
    // next state
    //========================================
    always_comb begin
        st_nxt = o_ctrl_st;
        if (st_active && fs_trig) begin
            st_nxt = hv_pkg::ST_FAILSAFE; // faults win over commands
        end else if (i_cmd_vld) begin
            case (i_cmd)
                hv_pkg::CMD_CFG: begin
                    if (o_ctrl_st == hv_pkg::ST_WAIT) begin
                        st_nxt = hv_pkg::ST_CFG;
                    end
                end
                hv_pkg::CMD_NORMAL: begin
                    if (o_ctrl_st == hv_pkg::ST_CFG) begin
                        st_nxt = hv_pkg::ST_NORMAL;
                    end
                end
                hv_pkg::CMD_RESET: begin
                    // failsafe is left only once the causes are gone
                    if (o_ctrl_st != hv_pkg::ST_FAILSAFE || (!i_flt_any && !i_wdg_tmo)) begin
                        st_nxt = hv_pkg::ST_WAIT;
                    end
                end
                hv_pkg::CMD_NOP, hv_pkg::CMD_CLR_FLT: begin
                    st_nxt = o_ctrl_st;
                end
                default: begin
                    st_nxt = o_ctrl_st;
                end
            endcase
        end
    end

    //========================================
    // state and output registers
    //========================================
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_ctrl_st <= hv_pkg::ST_WAIT;
            o_pwm_en  <= 1'b0;
            o_fsc_en  <= 1'b0;
            o_wdg_en  <= 1'b0;
            o_flt_clr <= 1'b0;
            o_intb_n  <= 1'b1;
        end else begin
            o_ctrl_st <= st_nxt;
            o_pwm_en  <= (o_ctrl_st == hv_pkg::ST_NORMAL);
            o_fsc_en  <= (o_ctrl_st == hv_pkg::ST_FAILSAFE);
            o_wdg_en  <= st_active;
            o_flt_clr <= i_cmd_vld && (i_cmd == hv_pkg::CMD_CLR_FLT); // one cycle pulse
            o_intb_n  <= ~(i_flt_any | i_wdg_tmo);
        end
    end

    a_en_excl: assert property (@(posedge i_clk) disable iff (i_rst)
        !(o_pwm_en && o_fsc_en));

    // pwm drops two cycles after a failsafe trigger in normal
    a_pwm_off: assert property (@(posedge i_clk) disable iff (i_rst)
        (o_ctrl_st == hv_pkg::ST_NORMAL && fs_trig) |=> ##1 !o_pwm_en);

endmodule

// ==== logic/hv_wdg_timer.sv ====
`timescale 1ns/1ps

module hv_wdg_timer (
    input  logic                         i_clk,
    input  logic                         i_rst,
    input  logic                         i_wdg_en,
    input  logic                         i_owt_rx_pulse,
    input  logic [hv_pkg::WDG_SEL_W-1:0] i_tmo_sel,
    input  logic                         i_flt_clr,
    output logic                         o_wdg_tmo
);

    logic [hv_pkg::WDG_CNT_W-1:0] cnt;
    logic [hv_pkg::WDG_CNT_W-1:0] cnt_nxt;
    logic [hv_pkg::WDG_CNT_W-1:0] tmo_lim;

    assign tmo_lim = hv_pkg::WDG_TMO_CYC[i_tmo_sel];

    always_comb begin
        if (!i_wdg_en || i_owt_rx_pulse) begin
            cnt_nxt = '0; // restart on rx activity
        end else if (cnt < tmo_lim) begin
            cnt_nxt = cnt + 1'b1;
        end else begin
            cnt_nxt = tmo_lim; // saturate, also clamps after a smaller select
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            cnt       <= '0;
            o_wdg_tmo <= 1'b0;
        end else begin
            cnt <= cnt_nxt;
            if (i_flt_clr) begin
                o_wdg_tmo <= 1'b0;
            end else if (cnt_nxt == tmo_lim) begin
                o_wdg_tmo <= 1'b1; // sticky
            end
        end
    end

    a_cnt_lim: assert property (@(posedge i_clk) disable iff (i_rst)
        $stable(i_tmo_sel) |-> (cnt <= tmo_lim));

endmodule

// ==== logic/hv_fault_filter.sv ====
`timescale 1ns/1ps

module hv_fault_filter (
    input  logic             i_clk,
    input  logic             i_rst,
    input  logic             i_hv_vcc_uv,
    input  logic             i_hv_vcc_ov,
    input  logic             i_hv_ot,
    input  logic             i_hv_oc,
    input  logic             i_hv_desat_flt,
    input  logic             i_hv_scp_flt,
    input  logic             i_flt_clr,
    output hv_pkg::flt_vec_t o_flt_status,
    output logic             o_flt_any
);

    hv_pkg::flt_vec_t flt_raw;
    hv_pkg::flt_vec_t flt_meta;
    hv_pkg::flt_vec_t flt_sync;

    logic [hv_pkg::FLT_DEB_W-1:0] deb_cnt [hv_pkg::FLT_NUM];

    assign flt_raw[hv_pkg::FLT_UV]    = i_hv_vcc_uv;
    assign flt_raw[hv_pkg::FLT_OV]    = i_hv_vcc_ov;
    assign flt_raw[hv_pkg::FLT_OT]    = i_hv_ot;
    assign flt_raw[hv_pkg::FLT_OC]    = i_hv_oc;
    assign flt_raw[hv_pkg::FLT_DESAT] = i_hv_desat_flt;
    assign flt_raw[hv_pkg::FLT_SCP]   = i_hv_scp_flt;

    // two flop synchronizer for the analog flags
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            flt_meta <= '0;
            flt_sync <= '0;
        end else begin
            flt_meta <= flt_raw;
            flt_sync <= flt_meta;
        end
    end

    //========================================
    // debounce and sticky latch per flag
    //========================================
    for (genvar i = 0; i < hv_pkg::FLT_NUM; i++) begin : g_flt
        always_ff @(posedge i_clk) begin
            if (i_rst) begin
                deb_cnt[i]      <= '0;
                o_flt_status[i] <= 1'b0;
            end else begin
                if (!flt_sync[i]) begin
                    deb_cnt[i] <= '0; // any low cycle restarts
                end else if (deb_cnt[i] != hv_pkg::FLT_DEB_W'(hv_pkg::FLT_DEB_CYC)) begin
                    deb_cnt[i] <= deb_cnt[i] + 1'b1;
                end

                if (i_flt_clr && !flt_sync[i]) begin
                    o_flt_status[i] <= 1'b0;
                end else if (deb_cnt[i] == hv_pkg::FLT_DEB_W'(hv_pkg::FLT_DEB_CYC)) begin
                    o_flt_status[i] <= 1'b1;
                end
            end
        end

        a_no_early: assert property (@(posedge i_clk) disable iff (i_rst)
            $rose(o_flt_status[i]) |->
                ($past(deb_cnt[i]) == hv_pkg::FLT_DEB_W'(hv_pkg::FLT_DEB_CYC)));
    end

    assign o_flt_any = |o_flt_status;

endmodule

// ==== logic/hv_pwm_gate.sv ====
`timescale 1ns/1ps

module hv_pwm_gate (
    input  logic i_clk,
    input  logic i_rst,
    input  logic i_ang_dgt_pwm_wv,
    input  logic i_ang_dgt_pwm_fs,
    input  logic i_pwm_en,
    output logic o_io_pwm_l2h,
    output logic o_fs_req
);

    logic [1:0] wv_sync; // [1] is the stable stage
    logic [1:0] fs_sync;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            wv_sync <= '0;
            fs_sync <= '0;
        end else begin
            wv_sync <= {wv_sync[0], i_ang_dgt_pwm_wv};
            fs_sync <= {fs_sync[0], i_ang_dgt_pwm_fs};
        end
    end

    // gated wave to the level shifter
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_io_pwm_l2h <= 1'b0;
        end else begin
            o_io_pwm_l2h <= wv_sync[1] & i_pwm_en;
        end
    end

    assign o_fs_req = fs_sync[1];

    a_gate_off: assert property (@(posedge i_clk) disable iff (i_rst)
        !i_pwm_en |=> !o_io_pwm_l2h);

endmodule

// ==== logic/hv_core.sv ====
`timescale 1ns/1ps

module hv_core (
    input  logic                         i_clk,
    input  logic                         i_rst,
    input  logic                         i_cmd_vld,
    input  hv_pkg::mode_cmd_e            i_cmd,
    input  logic                         i_lv_hv_owt_rx, // rx activity pulse
    input  logic [hv_pkg::WDG_SEL_W-1:0] i_wdg_tmo_sel,
    input  logic                         i_hv_vcc_uv,
    input  logic                         i_hv_vcc_ov,
    input  logic                         i_hv_ot,
    input  logic                         i_hv_oc,
    input  logic                         i_hv_desat_flt,
    input  logic                         i_hv_scp_flt,
    input  logic                         i_ang_dgt_pwm_wv,
    input  logic                         i_ang_dgt_pwm_fs,
    output hv_pkg::ctrl_st_e             o_ctrl_st,
    output hv_pkg::flt_vec_t             o_flt_status,
    output logic                         o_dgt_ang_pwm_en,
    output logic                         o_dgt_ang_fsc_en,
    output logic                         o_io_pwm_l2h,
    output logic                         o_intb_n
);

    //========================================
    // internal nets
    //========================================
    logic wdg_en;
    logic flt_clr;
    logic flt_any;
    logic wdg_tmo;
    logic fs_req;

    hv_ctrl_fsm u_ctrl_fsm (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_cmd_vld (i_cmd_vld),
        .i_cmd     (i_cmd),
        .i_flt_any (flt_any),
        .i_wdg_tmo (wdg_tmo),
        .i_fs_req  (fs_req),
        .o_ctrl_st (o_ctrl_st),
        .o_pwm_en  (o_dgt_ang_pwm_en),
        .o_fsc_en  (o_dgt_ang_fsc_en),
        .o_wdg_en  (wdg_en),
        .o_flt_clr (flt_clr),
        .o_intb_n  (o_intb_n)
    );

    hv_wdg_timer u_wdg_timer (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_wdg_en       (wdg_en),
        .i_owt_rx_pulse (i_lv_hv_owt_rx),
        .i_tmo_sel      (i_wdg_tmo_sel),
        .i_flt_clr      (flt_clr),
        .o_wdg_tmo      (wdg_tmo)
    );

    hv_fault_filter u_fault_filter (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_hv_vcc_uv    (i_hv_vcc_uv),
        .i_hv_vcc_ov    (i_hv_vcc_ov),
        .i_hv_ot        (i_hv_ot),
        .i_hv_oc        (i_hv_oc),
        .i_hv_desat_flt (i_hv_desat_flt),
        .i_hv_scp_flt   (i_hv_scp_flt),
        .i_flt_clr      (flt_clr),
        .o_flt_status   (o_flt_status),
        .o_flt_any      (flt_any)
    );

    hv_pwm_gate u_pwm_gate (
        .i_clk            (i_clk),
        .i_rst            (i_rst),
        .i_ang_dgt_pwm_wv (i_ang_dgt_pwm_wv),
        .i_ang_dgt_pwm_fs (i_ang_dgt_pwm_fs),
        .i_pwm_en         (o_dgt_ang_pwm_en), // gate straight from the fsm enable
        .o_io_pwm_l2h     (o_io_pwm_l2h),
        .o_fs_req         (fs_req)
    );

endmodule

// ==== verif/tb_hv_core.sv ====
`timescale 1ns/1ps

module tb_hv_core;

    localparam int MAX_CYC = 20000; // ~2x worst case, watchdog runs dominate

    logic                         clk;
    logic                         rst;
    logic                         cmd_vld;
    hv_pkg::mode_cmd_e            cmd;
    logic                         owt_rx;
    logic [hv_pkg::WDG_SEL_W-1:0] wdg_sel;
    hv_pkg::flt_vec_t             flt_in;
    logic                         pwm_wv;
    logic                         pwm_fs;
    hv_pkg::ctrl_st_e             ctrl_st;
    hv_pkg::flt_vec_t             flt_status;
    logic                         pwm_en;
    logic                         fsc_en;
    logic                         pwm_l2h;
    logic                         intb_n;

    logic [31:0]      lfsr = 32'h39fa_5750;
    hv_pkg::ctrl_st_e exp_st;
    hv_pkg::ctrl_st_e chk_st;
    logic             st_chk_req;
    int               rx_gap;   // 0 stops the rx pulses
    int               rx_cnt;
    int               cyc_cnt;
    int               idx;
    int               hold;
    int               lim;
    logic [31:0]      rnd;
    logic             wv_hist [20];

    hv_core dut0 (
        .i_clk            (clk),
        .i_rst            (rst),
        .i_cmd_vld        (cmd_vld),
        .i_cmd            (cmd),
        .i_lv_hv_owt_rx   (owt_rx),
        .i_wdg_tmo_sel    (wdg_sel),
        .i_hv_vcc_uv      (flt_in[hv_pkg::FLT_UV]),
        .i_hv_vcc_ov      (flt_in[hv_pkg::FLT_OV]),
        .i_hv_ot          (flt_in[hv_pkg::FLT_OT]),
        .i_hv_oc          (flt_in[hv_pkg::FLT_OC]),
        .i_hv_desat_flt   (flt_in[hv_pkg::FLT_DESAT]),
        .i_hv_scp_flt     (flt_in[hv_pkg::FLT_SCP]),
        .i_ang_dgt_pwm_wv (pwm_wv),
        .i_ang_dgt_pwm_fs (pwm_fs),
        .o_ctrl_st        (ctrl_st),
        .o_flt_status     (flt_status),
        .o_dgt_ang_pwm_en (pwm_en),
        .o_dgt_ang_fsc_en (fsc_en),
        .o_io_pwm_l2h     (pwm_l2h),
        .o_intb_n         (intb_n)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //========================================
    // reference model and helpers
    //========================================
    function automatic hv_pkg::ctrl_st_e next_state(hv_pkg::ctrl_st_e cur, logic vld,
            hv_pkg::mode_cmd_e c, logic flt_any, logic wdg_tmo, logic fs_req);
        hv_pkg::ctrl_st_e nxt;
        nxt = cur;
        if ((cur == hv_pkg::ST_CFG || cur == hv_pkg::ST_NORMAL) && (flt_any || wdg_tmo || fs_req)) begin
            nxt = hv_pkg::ST_FAILSAFE;
        end else if (vld) begin
            if (c == hv_pkg::CMD_CFG && cur == hv_pkg::ST_WAIT) begin
                nxt = hv_pkg::ST_CFG;
            end else if (c == hv_pkg::CMD_NORMAL && cur == hv_pkg::ST_CFG) begin
                nxt = hv_pkg::ST_NORMAL;
            end else if (c == hv_pkg::CMD_RESET &&
                    (cur != hv_pkg::ST_FAILSAFE || (!flt_any && !wdg_tmo))) begin
                nxt = hv_pkg::ST_WAIT;
            end
        end
        return nxt;
    endfunction

    // 3 to 11 cycles is a gray zone and never driven
    function automatic hv_pkg::flt_vec_t expect_status(int bit_idx, int held);
        hv_pkg::flt_vec_t v;
        v = '0;
        if (held >= 12) v[bit_idx] = 1'b1;
        return v;
    endfunction

    function automatic logic [31:0] take_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic abort_run(string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_st(string name, hv_pkg::ctrl_st_e exp, hv_pkg::ctrl_st_e act);
        if (act !== exp) begin
            abort_run($sformatf("[ERROR] %0t %s expected %s got %s",
                $time, name, exp.name(), act.name()));
        end
    endtask

    task automatic check_flt(string name, hv_pkg::flt_vec_t exp, hv_pkg::flt_vec_t act);
        if (act !== exp) begin
            abort_run($sformatf("[ERROR] %0t %s expected %b got %b", $time, name, exp, act));
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            abort_run($sformatf("[ERROR] %0t %s expected %b got %b", $time, name, exp, act));
        end
    endtask

    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic post_st_check(hv_pkg::ctrl_st_e st);
        chk_st     = st;
        exp_st     = st;
        st_chk_req = 1'b1;
    endtask

    // flags are the fault and timeout levels seen at the accepting edge
    task automatic issue_cmd(hv_pkg::mode_cmd_e c, logic flt_any, logic wdg_tmo);
        hv_pkg::ctrl_st_e nxt;
        nxt     = next_state(exp_st, 1'b1, c, flt_any, wdg_tmo, 1'b0);
        cmd_vld = 1'b1;
        cmd     = c;
        step_cycle();
        cmd_vld = 1'b0;
        cmd     = hv_pkg::CMD_NOP;
        post_st_check(nxt);
    endtask

    task automatic wait_for_state(hv_pkg::ctrl_st_e st, int max_cyc, string what);
        int n;
        n = 0;
        while (ctrl_st !== st && n < max_cyc) begin
            step_cycle();
            n++;
        end
        if (ctrl_st !== st) begin
            abort_run($sformatf("%s did not reach %s within %0d cycles", what, st.name(), max_cyc));
        end
        post_st_check(st);
    endtask

    task automatic wait_for_intb(logic val, int max_cyc);
        int n;
        n = 0;
        while (intb_n !== val && n < max_cyc) begin
            step_cycle();
            n++;
        end
        if (intb_n !== val) begin
            abort_run($sformatf("o_intb_n did not go to %b within %0d cycles", val, max_cyc));
        end
    endtask

    //========================================
    // background processes
    //========================================
    always @(negedge clk) begin
        if (st_chk_req) begin
            st_chk_req = 1'b0;
            check_st("o_ctrl_st", chk_st, ctrl_st);
        end
    end

    always begin
        @(posedge clk);
        #1;
        if (rx_gap == 0) begin
            rx_cnt = 0;
            owt_rx = 1'b0;
        end else begin
            rx_cnt++;
            owt_rx = (rx_cnt >= rx_gap);
            if (rx_cnt >= rx_gap) rx_cnt = 0;
        end
    end

    always @(posedge clk) begin
        cyc_cnt++;
        if (cyc_cnt >= MAX_CYC) abort_run($sformatf("timeout, run passed %0d cycles", cyc_cnt));
    end

    //========================================
    // stimulus
    //========================================
    initial begin
        rst        = 1'b1;
        cmd_vld    = 1'b0;
        cmd        = hv_pkg::CMD_NOP;
        owt_rx     = 1'b0;
        wdg_sel    = 2'd3;
        flt_in     = '0;
        pwm_wv     = 1'b0;
        pwm_fs     = 1'b0;
        exp_st     = hv_pkg::ST_WAIT;
        st_chk_req = 1'b0;
        rx_gap     = 16;
        rx_cnt     = 0;
        cyc_cnt    = 0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        check_st("o_ctrl_st", hv_pkg::ST_WAIT, ctrl_st);
        check_bit("o_dgt_ang_pwm_en", 1'b0, pwm_en);
        check_bit("o_dgt_ang_fsc_en", 1'b0, fsc_en);
        check_bit("o_io_pwm_l2h", 1'b0, pwm_l2h);
        check_bit("o_intb_n", 1'b1, intb_n);
        check_flt("o_flt_status", '0, flt_status);

        issue_cmd(hv_pkg::CMD_CFG, 1'b0, 1'b0);
        issue_cmd(hv_pkg::CMD_NORMAL, 1'b0, 1'b0);
        step_cycle();
        check_bit("o_dgt_ang_pwm_en", 1'b1, pwm_en);
        for (int i = 0; i < 20; i++) begin
            step_cycle();
            if (i >= 3) check_bit("o_io_pwm_l2h", wv_hist[i-3], pwm_l2h); // 3 cycle path
            rnd        = take_bits(1);
            wv_hist[i] = rnd[0];
            pwm_wv     = wv_hist[i];
        end
        pwm_wv = 1'b0;

        // glitches too short for the debounce
        repeat (3) begin
            idx         = int'(take_bits(3) % 32'd6);
            hold        = 1 + int'(take_bits(1));
            flt_in[idx] = 1'b1;
            repeat (hold) step_cycle();
            flt_in[idx] = 1'b0;
            repeat (10) step_cycle();
            check_flt("o_flt_status", expect_status(idx, hold), flt_status);
            check_st("o_ctrl_st", exp_st, ctrl_st);
        end

        idx         = int'(take_bits(3) % 32'd6);
        hold        = 12 + int'(take_bits(2));
        flt_in[idx] = 1'b1;
        repeat (hold) step_cycle();
        check_flt("o_flt_status", expect_status(idx, hold), flt_status);
        post_st_check(next_state(exp_st, 1'b0, hv_pkg::CMD_NOP, 1'b1, 1'b0, 1'b0));
        check_bit("o_dgt_ang_fsc_en", 1'b1, fsc_en);
        check_bit("o_dgt_ang_pwm_en", 1'b0, pwm_en);
        check_bit("o_intb_n", 1'b0, intb_n);

        //========================================
        // failsafe exit
        //========================================
        issue_cmd(hv_pkg::CMD_RESET, 1'b1, 1'b0); // input still high
        flt_in = '0;
        repeat (4) step_cycle();
        issue_cmd(hv_pkg::CMD_CLR_FLT, 1'b1, 1'b0);
        wait_for_intb(1'b1, 6);
        check_flt("o_flt_status", '0, flt_status);
        issue_cmd(hv_pkg::CMD_RESET, 1'b0, 1'b0);

        // watchdog, one random select per pass
        repeat (4) begin
            rnd     = take_bits(2);
            wdg_sel = rnd[1:0];
            lim     = 64 << int'(rnd[1:0]);
            issue_cmd(hv_pkg::CMD_CFG, 1'b0, 1'b0);
            issue_cmd(hv_pkg::CMD_NORMAL, 1'b0, 1'b0);
            rx_gap = lim / 2;
            repeat (4 * lim) begin
                step_cycle();
                check_st("o_ctrl_st", hv_pkg::ST_NORMAL, ctrl_st);
            end
            rx_gap = 0;
            wait_for_state(next_state(exp_st, 1'b0, hv_pkg::CMD_NOP, 1'b0, 1'b1, 1'b0),
                lim + 8, "watchdog timeout");
            check_flt("o_flt_status", '0, flt_status);
            check_bit("o_intb_n", 1'b0, intb_n);
            issue_cmd(hv_pkg::CMD_CLR_FLT, 1'b0, 1'b1);
            wait_for_intb(1'b1, 6);
            rx_gap = 16;
            issue_cmd(hv_pkg::CMD_RESET, 1'b0, 1'b0);
        end

        issue_cmd(hv_pkg::CMD_CFG, 1'b0, 1'b0);
        pwm_fs = 1'b1;
        wait_for_state(next_state(exp_st, 1'b0, hv_pkg::CMD_NOP, 1'b0, 1'b0, 1'b1),
            4, "analog failsafe request");
        pwm_fs = 1'b0;

        repeat (4) step_cycle();
        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== sim.f ====
logic/hv_pkg.sv
logic/hv_ctrl_fsm.sv
logic/hv_wdg_timer.sv
logic/hv_fault_filter.sv
logic/hv_pwm_gate.sv
logic/hv_core.sv
verif/tb_hv_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the hv_core testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_hv_core \
    -f sim.f -Mdir obj_dir -o tb_hv_core > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "verilator build failed, see build.log"
    exit 1
fi

./obj_dir/tb_hv_core > sim.log 2>&1
run_status=$?
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
fi

if grep -qx "Finished with no errors" sim.log; then
    echo "PASS"
    exit 0
fi
echo "FAIL, see sim.log"
exit 1
